// File: hdl/alu_execute.sv
/* combinational execute stage; shifts use the low 5 bits of operand b,
   branches compare for equality only */
`default_nettype none

module alu_execute (
	input soc_pkg::dec_inst_t dec,
	input wire  [31:0]        rs1_val,
	input wire  [31:0]        rs2_val,
	input wire  [31:0]        pc,
	output logic [31:0]       alu_result,
	output logic              branch_taken,
	output logic [31:0]       next_pc,
	output logic [31:0]       mem_addr
);

	logic [31:0] op_b;
	logic [31:0] target;

	assign op_b = dec.use_imm ? dec.imm : rs2_val;

	always_comb
	begin
		case (dec.alu_op)
			soc_pkg::alu_add:    alu_result = rs1_val + op_b;
			soc_pkg::alu_sub:    alu_result = rs1_val - op_b;
			soc_pkg::alu_and:    alu_result = rs1_val & op_b;
			soc_pkg::alu_or:     alu_result = rs1_val | op_b;
			soc_pkg::alu_xor:    alu_result = rs1_val ^ op_b;
			soc_pkg::alu_slt:    alu_result = {31'b0, $signed(rs1_val) < $signed(op_b)};
			soc_pkg::alu_sll:    alu_result = rs1_val << op_b[4:0];
			soc_pkg::alu_srl:    alu_result = rs1_val >> op_b[4:0];
			soc_pkg::alu_pass_b: alu_result = op_b;
			default:             alu_result = 32'h0000_0000;
		endcase
	end

	// bne flips the sense of the equality test
	assign branch_taken = dec.is_branch & ((rs1_val == rs2_val) ^ dec.branch_ne);

	// same pc-relative target for jal and branches
	assign target  = pc + dec.imm;
	assign next_pc = (dec.is_jal || branch_taken) ? target : pc + 32'd4;

	assign mem_addr = rs1_val + dec.imm;

endmodule

`default_nettype wire

// File: hdl/cpu_core.sv
/* multi-cycle RV32I subset core with one instruction in flight; fetch must be word aligned
   and rdy low freezes every state and write */
`default_nettype none
`include "soc_params.svh"

module cpu_core (
	input wire          clk,
	input wire          rst,
	input wire          rdy,
	mem_bus_if.master   bus,
	output logic        halted,
	output logic [31:0] dbg_reg
);

	soc_pkg::core_state_e state;
	soc_pkg::dec_inst_t   dec;
	soc_pkg::dec_inst_t   dec_q;

	// fetch byte index and phase or load phase
	logic [2:0]  cnt;
	logic [31:0] pc;
	logic [31:0] ir;
	logic [31:0] fetch_addr;
	logic [31:0] alu_result;
	logic [31:0] alu_q;
	logic [31:0] next_pc;
	logic [31:0] next_pc_q;
	logic [31:0] mem_addr;
	logic [31:0] addr_q;
	logic [7:0]  load_q;
	logic [31:0] rs1_val;
	logic [31:0] rs2_val;
	logic        reg_we;

	inst_decode dec0 (
		.inst (ir),
		.dec  (dec)
	);

	alu_execute exe0 (
		.dec          (dec_q),
		.rs1_val      (rs1_val),
		.rs2_val      (rs2_val),
		.pc           (pc),
		.alu_result   (alu_result),
		.branch_taken (),
		.next_pc      (next_pc),
		.mem_addr     (mem_addr)
	);

	reg_result res0 (
		.clk        (clk),
		.rst        (rst),
		.we         (reg_we),
		.dec        (dec_q),
		.alu_result (alu_q),
		.load_byte  (load_q),
		.pc         (pc),
		.rs1_val    (rs1_val),
		.rs2_val    (rs2_val),
		.x10        (dbg_reg)
	);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state <= soc_pkg::st_fetch;
			cnt   <= 3'd0;
			pc    <= `SOC_RESET_PC;
		end
		else if (rdy)
		begin
			case (state)
				soc_pkg::st_fetch:
				begin
					// two cycles per byte and wraps to 0 after the fourth
					cnt <= cnt + 3'd1;
					if (cnt == 3'd7)
						state <= soc_pkg::st_decode;
				end
				soc_pkg::st_decode:
				begin
					if (dec.halt || dec.illegal)
						state <= soc_pkg::st_halt;
					else
						state <= soc_pkg::st_exec;
				end
				soc_pkg::st_exec:
				begin
					if (dec_q.is_load || dec_q.is_store)
						state <= soc_pkg::st_mem;
					else
						state <= soc_pkg::st_result;
				end
				soc_pkg::st_mem:
				begin
					if (dec_q.is_store || cnt[0])
					begin
						state <= soc_pkg::st_result;
						cnt   <= 3'd0;
					end
					else
						cnt <= cnt + 3'd1;
				end
				soc_pkg::st_result:
				begin
					pc    <= next_pc_q;
					state <= soc_pkg::st_fetch;
				end
				default:
				begin
					state <= soc_pkg::st_halt;
				end
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (rdy)
		begin
			// little endian assembly with each byte taken in its second phase
			if (state == soc_pkg::st_fetch && cnt[0])
				ir[{cnt[2:1], 3'b000} +: 8] <= bus.din;
			if (state == soc_pkg::st_decode)
				dec_q <= dec;
			if (state == soc_pkg::st_exec)
			begin
				alu_q     <= alu_result;
				next_pc_q <= next_pc;
				addr_q    <= mem_addr;
			end
			if (state == soc_pkg::st_mem && cnt[0])
				load_q <= bus.din;
		end
	end

	assign fetch_addr = pc + {30'b0, cnt[2:1]};

	assign bus.a    = (state == soc_pkg::st_mem) ? addr_q[`SOC_RAM_AW:0]
	                                             : fetch_addr[`SOC_RAM_AW:0];
	assign bus.dout = rs2_val[7:0];
	assign bus.wr   = rdy & (state == soc_pkg::st_mem) & dec_q.is_store;

	assign reg_we = rdy & (state == soc_pkg::st_result);
	assign halted = (state == soc_pkg::st_halt);

	// stores carry a known address and byte
	a_wr_known: assert property (@(posedge clk) disable iff (rst)
		bus.wr |-> !$isunknown({bus.a, bus.dout}));

endmodule

`default_nettype wire

// File: hdl/inst_decode.sv
/* combinational RV32I subset decoder; anything outside the subset sets illegal,
   only the exact EBREAK encoding sets halt */
`default_nettype none

module inst_decode (
	input wire  [31:0]       inst,
	output soc_pkg::dec_inst_t dec
);

	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'h000};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb
	begin
		dec        = '0;
		dec.rd     = inst[11:7];
		dec.rs1    = inst[19:15];
		dec.rs2    = inst[24:20];
		dec.alu_op = soc_pkg::alu_add;
		case (soc_pkg::opcode_e'(inst[6:0]))
			soc_pkg::opc_lui:
			begin
				dec.imm       = imm_u;
				dec.alu_op    = soc_pkg::alu_pass_b;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
			end
			soc_pkg::opc_jal:
			begin
				dec.imm       = imm_j;
				dec.is_jal    = 1'b1;
				dec.reg_write = 1'b1;
			end
			soc_pkg::opc_branch:
			begin
				dec.imm       = imm_b;
				dec.is_branch = 1'b1;
				dec.branch_ne = funct3[0];
				// beq and bne only
				dec.illegal   = (funct3[2:1] != 2'b00);
			end
			soc_pkg::opc_load:
			begin
				dec.imm           = imm_i;
				dec.is_load       = 1'b1;
				dec.use_imm       = 1'b1;
				dec.reg_write     = 1'b1;
				dec.load_unsigned = funct3[2];
				dec.illegal       = (funct3[1:0] != 2'b00);
			end
			soc_pkg::opc_store:
			begin
				dec.imm      = imm_s;
				dec.is_store = 1'b1;
				dec.illegal  = (funct3 != 3'b000);
			end
			soc_pkg::opc_op_imm:
			begin
				dec.imm       = imm_i;
				dec.use_imm   = 1'b1;
				dec.reg_write = 1'b1;
				case (funct3)
					3'b000:  dec.alu_op = soc_pkg::alu_add;
					3'b010:  dec.alu_op = soc_pkg::alu_slt;
					3'b100:  dec.alu_op = soc_pkg::alu_xor;
					3'b110:  dec.alu_op = soc_pkg::alu_or;
					3'b111:  dec.alu_op = soc_pkg::alu_and;
					default: dec.illegal = 1'b1;
				endcase
			end
			soc_pkg::opc_op:
			begin
				dec.reg_write = 1'b1;
				case ({funct7, funct3})
					10'b0000000_000: dec.alu_op = soc_pkg::alu_add;
					10'b0100000_000: dec.alu_op = soc_pkg::alu_sub;
					10'b0000000_001: dec.alu_op = soc_pkg::alu_sll;
					10'b0000000_010: dec.alu_op = soc_pkg::alu_slt;
					10'b0000000_100: dec.alu_op = soc_pkg::alu_xor;
					10'b0000000_101: dec.alu_op = soc_pkg::alu_srl;
					10'b0000000_110: dec.alu_op = soc_pkg::alu_or;
					10'b0000000_111: dec.alu_op = soc_pkg::alu_and;
					default:         dec.illegal = 1'b1;
				endcase
			end
			soc_pkg::opc_system:
			begin
				dec.halt    = (inst == 32'h0010_0073);
				dec.illegal = (inst != 32'h0010_0073);
			end
			default:
			begin
				dec.illegal = 1'b1;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hdl/io_port.sv
/* one output byte register at the I/O region; reads from that region return zero
   and rdata is aligned with the one-cycle RAM read latency */
`default_nettype none
`include "soc_params.svh"

module io_port (
	input wire         clk,
	input wire         rst,
	mem_bus_if.slave   bus,
	input wire  [7:0]  ram_dout,
	output logic [7:0] rdata,
	output logic [7:0] io_data,
	output logic       io_strobe
);

	logic io_hit;
	logic io_hit_q;

	assign io_hit = (bus.a[`SOC_RAM_AW:`SOC_RAM_AW-1] == `SOC_IO_SEL);

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			io_data   <= 8'h00;
			io_strobe <= 1'b0;
			io_hit_q  <= 1'b0;
		end
		else
		begin
			// strobe lands in the cycle after the store
			io_strobe <= io_hit & bus.wr;
			if (io_hit && bus.wr)
			begin
				io_data <= bus.dout;
			end
			io_hit_q <= io_hit;
		end
	end

	assign rdata = io_hit_q ? 8'h00 : ram_dout;

	// a store spends a single cycle on the bus, so the pulse never stretches
	a_strobe_single: assert property (@(posedge clk) disable iff (rst)
		io_strobe |=> !io_strobe);

endmodule

`default_nettype wire

// File: hdl/mem_bus_if.sv
/* byte-wide memory bus; no handshake, a read returns data one cycle after the address */
`default_nettype none
`include "soc_params.svh"

interface mem_bus_if;

	// extra top bit selects the I/O region
	logic [`SOC_RAM_AW:0] a;
	// write data from the master
	logic [7:0]           dout;
	// read data towards the master
	logic [7:0]           din;
	logic                 wr;

	modport master (
		output a,
		output dout,
		output wr,
		input  din
	);

	modport slave (
		input  a,
		input  dout,
		input  wr,
		output din
	);

endinterface

`default_nettype wire

// File: hdl/ram.sv
/* single-port byte RAM, registered read; contents are undefined until loaded */
`default_nettype none
`include "soc_params.svh"

module ram (
	input wire        clk,
	mem_bus_if.slave  bus,
	input wire        en
);

	localparam int DEPTH = 2 ** `SOC_RAM_AW;

	logic [7:0]               mem [0:DEPTH-1];
	logic [`SOC_RAM_AW-1:0]   addr;

	assign addr = bus.a[`SOC_RAM_AW-1:0];

	// read-before-write, din valid the cycle after the address
	always_ff @(posedge clk)
	begin
		if (en)
		begin
			if (bus.wr)
			begin
				mem[addr] <= bus.dout;
			end
			bus.din <= mem[addr];
		end
	end

endmodule

`default_nettype wire

// File: hdl/reg_result.sv
/* 31 general registers plus hardwired x0; register contents are undefined after reset
   and only bytes are loaded */
`default_nettype none

module reg_result (
	input wire                clk,
	input wire                rst,
	input wire                we,
	input soc_pkg::dec_inst_t dec,
	input wire  [31:0]        alu_result,
	input wire  [7:0]         load_byte,
	input wire  [31:0]        pc,
	output logic [31:0]       rs1_val,
	output logic [31:0]       rs2_val,
	output logic [31:0]       x10
);

	logic [31:0] regs [1:31];
	logic [31:0] load_val;
	logic [31:0] wb_val;

	// lb sign extends, lbu zero extends
	assign load_val = dec.load_unsigned ? {24'h000000, load_byte}
	                                    : {{24{load_byte[7]}}, load_byte};

	always_comb
	begin
		if (dec.is_jal)
			wb_val = pc + 32'd4;
		else if (dec.is_load)
			wb_val = load_val;
		else
			wb_val = alu_result;
	end

	always_ff @(posedge clk)
	begin
		if (we && dec.reg_write && (dec.rd != 5'd0))
		begin
			regs[dec.rd] <= wb_val;
		end
	end

	assign rs1_val = (dec.rs1 == 5'd0) ? 32'h0000_0000 : regs[dec.rs1];
	assign rs2_val = (dec.rs2 == 5'd0) ? 32'h0000_0000 : regs[dec.rs2];
	assign x10     = regs[10];

	// catches reads of never-written registers reaching the file
	a_wb_known: assert property (@(posedge clk) disable iff (rst)
		(we && dec.reg_write) |-> !$isunknown(wb_val));

endmodule

`default_nettype wire

// File: hdl/riscv_top.sv
/* SoC top: core, 128 KiB RAM and output port; clk comes straight in, btnC resets
   asynchronously, and load_en hands the bus to the host loader and stalls the core */
`default_nettype none
`include "soc_params.svh"

module riscv_top (
	input wire                   clk,
	input wire                   btnC,
	input wire                   load_en,
	input wire [`SOC_RAM_AW-1:0] load_addr,
	input wire [7:0]             load_data,
	output logic [7:0]           io_data,
	output logic                 io_strobe,
	output logic                 led,
	output logic [31:0]          dbg_reg
);

	logic       rst;
	logic       rst_delay;
	logic       cpu_rdy;
	logic       halted;
	logic       ram_en;
	logic [7:0] rdata;

	mem_bus_if core_bus ();
	mem_bus_if sys_bus ();

	// release takes two clocks after btnC drops
	always_ff @(posedge clk or posedge btnC)
	begin
		if (btnC)
		begin
			rst       <= 1'b1;
			rst_delay <= 1'b1;
		end
		else
		begin
			rst_delay <= 1'b0;
			rst       <= rst_delay;
		end
	end

	assign cpu_rdy = ~load_en;

	cpu_core core0 (
		.clk     (clk),
		.rst     (rst),
		.rdy     (cpu_rdy),
		.bus     (core_bus.master),
		.halted  (halted),
		.dbg_reg (dbg_reg)
	);

	// host loader owns the bus while load_en is high, RAM space only
	assign sys_bus.a    = load_en ? {1'b0, load_addr} : core_bus.a;
	assign sys_bus.dout = load_en ? load_data : core_bus.dout;
	assign sys_bus.wr   = load_en | core_bus.wr;

	assign ram_en = (sys_bus.a[`SOC_RAM_AW:`SOC_RAM_AW-1] != `SOC_IO_SEL);

	ram ram0 (
		.clk (clk),
		.bus (sys_bus.slave),
		.en  (ram_en)
	);

	io_port io0 (
		.clk       (clk),
		.rst       (rst),
		.bus       (sys_bus.slave),
		.ram_dout  (sys_bus.din),
		.rdata     (rdata),
		.io_data   (io_data),
		.io_strobe (io_strobe)
	);

	assign core_bus.din = rdata;

	assign led = halted;

endmodule

`default_nettype wire

// File: hdl/soc_pkg.sv
/* types shared by the core and its decode, execute and result stages */
`default_nettype none

package soc_pkg;

	// major RV32I opcodes that the core knows about
	typedef enum logic [6:0] {
		opc_lui    = 7'b0110111,
		opc_jal    = 7'b1101111,
		opc_branch = 7'b1100011,
		opc_load   = 7'b0000011,
		opc_store  = 7'b0100011,
		opc_op_imm = 7'b0010011,
		opc_op     = 7'b0110011,
		opc_system = 7'b1110011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt,
		alu_sll,
		alu_srl,
		alu_pass_b
	} alu_op_e;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_exec,
		st_mem,
		st_result,
		st_halt
	} core_state_e;

	typedef struct packed {
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [31:0] imm;
		alu_op_e     alu_op;
		logic        is_load;
		logic        is_store;
		logic        is_branch;
		logic        branch_ne;
		logic        is_jal;
		logic        load_unsigned;
		logic        use_imm;
		logic        reg_write;
		logic        illegal;
		// ebreak
		logic        halt;
	} dec_inst_t;

endpackage

`default_nettype wire

// File: include/soc_params.svh
/* shared sizes for the SoC; RAM is 2**SOC_RAM_AW bytes and bus addresses carry one extra bit
   so that bits [SOC_RAM_AW:SOC_RAM_AW-1] can select the I/O region */
`ifndef SOC_PARAMS_SVH
`define SOC_PARAMS_SVH

// 128 KiB of byte-wide RAM
`define SOC_RAM_AW 17

// value of address bits 17:16 that maps to the output port
`define SOC_IO_SEL 2'b11

// first instruction is fetched from here after reset
`define SOC_RESET_PC 32'h0000_0000

`endif

// File: riscv_top.f
+incdir+include
hdl/soc_pkg.sv
hdl/mem_bus_if.sv
hdl/ram.sv
hdl/io_port.sv
hdl/inst_decode.sv
hdl/alu_execute.sv
hdl/reg_result.sv
hdl/cpu_core.sv
hdl/riscv_top.sv
tests/riscv_top_tb.sv

// File: run.sh
#!/bin/sh
# build and run the riscv_top testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f riscv_top.f --top-module riscv_top_tb \
	-Mdir obj_dir -o riscv_top_sim

out=$(./obj_dir/riscv_top_sim)
echo "$out"

# the run passes only when the pass message was printed
echo "$out" | grep -q "ALL CHECKS PASSED"

// File: tests/riscv_top_tb.sv
/* table-driven testbench for riscv_top; programs are loaded at the reset vector and each
   one must end in ebreak or an illegal word, since a test ends when led rises */
`default_nettype none
`include "soc_params.svh"

module riscv_top_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_tests        = 6;
	localparam int max_words        = 12;
	localparam int max_io           = 4;
	localparam int clk_period       = 8;
	localparam int reset_cycles     = 16;
	localparam int instr_cycles     = 13;
	localparam int post_halt_cycles = 24;
	localparam int drive_dly        = 1;
	localparam int watchdog_cycles  =
		num_tests * (max_words * 4 + max_words * instr_cycles + reset_cycles + 4) * 2;

	localparam logic [6:0]  opc_op_imm = 7'b0010011;
	localparam logic [6:0]  opc_load   = 7'b0000011;
	localparam logic [31:0] ebreak     = 32'h0010_0073;
	// start of the output port region
	localparam logic [31:0] io_base    = {14'b0, `SOC_IO_SEL, 16'h0000};

	logic                   clk;
	logic                   btnC;
	logic                   load_en;
	logic [`SOC_RAM_AW-1:0] load_addr;
	logic [7:0]             load_data;
	logic [7:0]             io_data;
	logic                   io_strobe;
	logic                   led;
	logic [31:0]            dbg_reg;

	// stimulus and expected values with one row per test
	string       test_name [num_tests];
	logic [31:0] prog [num_tests][max_words];
	int          prog_len [num_tests];
	int          hold_cycles [num_tests];
	logic [7:0]  exp_io [num_tests][max_io];
	int          exp_io_cnt [num_tests];
	logic [31:0] exp_dbg [num_tests];

	logic [31:0] rng_state;
	int          test_errors;
	int          total_errors;
	int          tests_passed;
	int          tests_failed;

	riscv_top uut (
		.clk       (clk),
		.btnC      (btnC),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.io_data   (io_data),
		.io_strobe (io_strobe),
		.led       (led),
		.dbg_reg   (dbg_reg)
	);

	initial clk = 1'b0;

	always #(clk_period / 2) clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// RV32I instruction formats
	function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd, input logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	// sb only
	function automatic logic [31:0] stype(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b000, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] btype(input logic [12:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	// lui only
	function automatic logic [31:0] utype(input logic [19:0] imm, input logic [4:0] rd);
		return {imm, rd, 7'b0110111};
	endfunction

	function automatic logic [31:0] jtype(input logic [20:0] imm, input logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic append_instr(input int t, input logic [31:0] word);
		prog[t][prog_len[t]] = word;
		prog_len[t]++;
	endtask

	task automatic expect_io_byte(input int t, input logic [7:0] value);
		exp_io[t][exp_io_cnt[t]] = value;
		exp_io_cnt[t]++;
	endtask

	task automatic build_table();
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] v;
		logic [31:0] s;
		logic [31:0] sum_a;
		logic [31:0] sum_b;
		logic [31:0] lb_val;
		logic [31:0] lbu_val;
		for (int t = 0; t < num_tests; t++)
		begin
			prog_len[t]    = 0;
			exp_io_cnt[t]  = 0;
			hold_cycles[t] = 0;
			exp_dbg[t]     = 32'h0000_0000;
		end

		// lui, addi, logic immediates and slti with bytes sent to the port
		test_name[0] = "imm_arith_io";
		append_instr(0, utype(io_base[31:12], 5'd2));
		append_instr(0, itype(12'h025, 5'd0, 3'b000, 5'd1, opc_op_imm));
		append_instr(0, stype(12'h000, 5'd1, 5'd2));
		append_instr(0, utype(20'h12345, 5'd3));
		append_instr(0, itype(12'h678, 5'd3, 3'b000, 5'd3, opc_op_imm));
		append_instr(0, stype(12'h000, 5'd3, 5'd2));
		append_instr(0, itype(12'h0f0, 5'd3, 3'b111, 5'd4, opc_op_imm));
		append_instr(0, itype(12'h00c, 5'd4, 3'b110, 5'd4, opc_op_imm));
		append_instr(0, itype(12'h0ff, 5'd4, 3'b100, 5'd4, opc_op_imm));
		append_instr(0, stype(12'h000, 5'd4, 5'd2));
		append_instr(0, itype(12'h030, 5'd1, 3'b010, 5'd10, opc_op_imm));
		append_instr(0, ebreak);
		expect_io_byte(0, 8'h25);
		v = 32'h1234_5000 + 32'h0000_0678;
		expect_io_byte(0, v[7:0]);
		v = ((v & 32'h0000_00f0) | 32'h0000_000c) ^ 32'h0000_00ff;
		expect_io_byte(0, v[7:0]);
		exp_dbg[0] = ($signed(32'h0000_0025) < $signed(32'h0000_0030)) ? 32'd1 : 32'd0;

		// register ALU chain where a is negative so slt differs from an unsigned compare
		test_name[1] = "reg_alu";
		a = 32'h8765_4000 + 32'h0000_0321;
		b = 32'h0000_05a3;
		append_instr(1, utype(20'h87654, 5'd1));
		append_instr(1, itype(12'h321, 5'd1, 3'b000, 5'd1, opc_op_imm));
		append_instr(1, itype(12'h5a3, 5'd0, 3'b000, 5'd2, opc_op_imm));
		append_instr(1, rtype(7'b0000000, 5'd2, 5'd1, 3'b000, 5'd3));
		append_instr(1, rtype(7'b0100000, 5'd2, 5'd1, 3'b000, 5'd4));
		append_instr(1, rtype(7'b0000000, 5'd4, 5'd3, 3'b111, 5'd10));
		append_instr(1, rtype(7'b0000000, 5'd2, 5'd10, 3'b110, 5'd10));
		append_instr(1, rtype(7'b0000000, 5'd1, 5'd10, 3'b100, 5'd10));
		append_instr(1, rtype(7'b0000000, 5'd2, 5'd1, 3'b010, 5'd5));
		append_instr(1, rtype(7'b0000000, 5'd5, 5'd10, 3'b001, 5'd10));
		append_instr(1, rtype(7'b0000000, 5'd2, 5'd10, 3'b101, 5'd10));
		append_instr(1, ebreak);
		v = (a + b) & (a - b);
		v = (v | b) ^ a;
		s = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
		v = v << s[4:0];
		v = v >> b[4:0];
		exp_dbg[1] = v;

		// byte store to RAM, then signed and unsigned reload
		test_name[2] = "byte_mem";
		lb_val   = 32'hffff_fff0;
		lbu_val  = 32'h0000_00f0;
		append_instr(2, utype(io_base[31:12], 5'd2));
		append_instr(2, itype(12'h0f0, 5'd0, 3'b000, 5'd1, opc_op_imm));
		append_instr(2, stype(12'h400, 5'd1, 5'd0));
		append_instr(2, itype(12'h400, 5'd0, 3'b000, 5'd4, opc_load));
		append_instr(2, itype(12'h400, 5'd0, 3'b100, 5'd10, opc_load));
		append_instr(2, stype(12'h000, 5'd4, 5'd2));
		append_instr(2, itype(12'h018, 5'd0, 3'b000, 5'd6, opc_op_imm));
		append_instr(2, rtype(7'b0000000, 5'd6, 5'd4, 3'b101, 5'd7));
		append_instr(2, stype(12'h000, 5'd7, 5'd2));
		append_instr(2, stype(12'h000, 5'd10, 5'd2));
		append_instr(2, ebreak);
		expect_io_byte(2, lb_val[7:0]);
		v = lb_val >> 24;
		expect_io_byte(2, v[7:0]);
		expect_io_byte(2, lbu_val[7:0]);
		exp_dbg[2] = lbu_val;

		// countdown loop where a taken beq and jal both skip a store
		test_name[3] = "branch_jal";
		append_instr(3, itype(12'h003, 5'd0, 3'b000, 5'd1, opc_op_imm));
		append_instr(3, utype(io_base[31:12], 5'd2));
		append_instr(3, stype(12'h000, 5'd1, 5'd2));
		append_instr(3, itype(12'hfff, 5'd1, 3'b000, 5'd1, opc_op_imm));
		append_instr(3, btype(13'h1ff8, 5'd0, 5'd1, 3'b001));
		append_instr(3, btype(13'h0008, 5'd0, 5'd1, 3'b000));
		append_instr(3, stype(12'h000, 5'd2, 5'd2));
		append_instr(3, jtype(21'h000008, 5'd10));
		append_instr(3, stype(12'h000, 5'd2, 5'd2));
		append_instr(3, ebreak);
		for (int c = 3; c > 0; c--)
		begin
			expect_io_byte(3, 8'(c));
		end
		// jal sits in word 7
		exp_dbg[3] = `SOC_RESET_PC + 32'd28 + 32'd4;

		// random operands where lui takes the upper part rounded for the signed addi
		test_name[4] = "random_add_xor";
		rng_state = lcg_next(rng_state);
		a = rng_state;
		rng_state = lcg_next(rng_state);
		b = rng_state;
		sum_a = a + 32'h0000_0800;
		sum_b = b + 32'h0000_0800;
		append_instr(4, utype(sum_a[31:12], 5'd3));
		append_instr(4, itype(a[11:0], 5'd3, 3'b000, 5'd3, opc_op_imm));
		append_instr(4, utype(sum_b[31:12], 5'd4));
		append_instr(4, itype(b[11:0], 5'd4, 3'b000, 5'd4, opc_op_imm));
		append_instr(4, rtype(7'b0000000, 5'd4, 5'd3, 3'b000, 5'd5));
		append_instr(4, rtype(7'b0000000, 5'd3, 5'd5, 3'b100, 5'd10));
		append_instr(4, utype(io_base[31:12], 5'd2));
		append_instr(4, stype(12'h000, 5'd10, 5'd2));
		append_instr(4, ebreak);
		v = (a + b) ^ a;
		expect_io_byte(4, v[7:0]);
		exp_dbg[4] = v;

		// held by the loader first, then an illegal word stops the core
		test_name[5]   = "halt_hold";
		hold_cycles[5] = 64;
		append_instr(5, itype(12'h05a, 5'd0, 3'b000, 5'd10, opc_op_imm));
		append_instr(5, utype(io_base[31:12], 5'd2));
		append_instr(5, stype(12'h000, 5'd10, 5'd2));
		append_instr(5, 32'hffff_ffff);
		append_instr(5, stype(12'h001, 5'd10, 5'd2));
		expect_io_byte(5, 8'h5a);
		exp_dbg[5] = 32'h0000_005a;
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#drive_dly;
	endtask

	task automatic check_quiet(input int t);
		@(negedge clk);
		if (io_strobe || led)
		begin
			$display("%s: core active while the host loader owns the bus", test_name[t]);
			test_errors++;
		end
	endtask

	task automatic run_test(input int t);
		logic [31:0] addr;
		int          io_cnt;
		logic        done;
		test_errors = 0;
		io_cnt      = 0;
		done        = 1'b0;

		// loader takes the bus before reset drops so the core never runs old code
		next_cycle();
		load_en = 1'b1;
		btnC    = 1'b1;
		repeat (reset_cycles) @(posedge clk);
		#drive_dly;
		btnC = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		if (io_strobe !== 1'b0 || led !== 1'b0 || io_data !== 8'h00)
		begin
			$display("ERROR %s: strobe/led/data after reset expected 0/0/00 actual %b/%b/%h",
				test_name[t], io_strobe, led, io_data);
			test_errors++;
		end

		for (int w = 0; w < prog_len[t]; w++)
		begin
			for (int b = 0; b < 4; b++)
			begin
				next_cycle();
				addr      = `SOC_RESET_PC + 32'(w * 4 + b);
				load_addr = addr[`SOC_RAM_AW-1:0];
				load_data = prog[t][w][8 * b +: 8];
				check_quiet(t);
			end
		end
		for (int c = 0; c < hold_cycles[t]; c++)
		begin
			next_cycle();
			check_quiet(t);
		end
		next_cycle();
		load_en = 1'b0;

		// run until led rises
		while (!done)
		begin
			@(negedge clk);
			if (io_strobe)
			begin
				if (io_cnt < exp_io_cnt[t])
				begin
					if (io_data !== exp_io[t][io_cnt])
					begin
						$display("ERROR %s: io byte %0d expected %h actual %h",
							test_name[t], io_cnt, exp_io[t][io_cnt], io_data);
						test_errors++;
					end
				end
				else
				begin
					$display("%s: extra io_strobe with io_data %h", test_name[t], io_data);
					test_errors++;
				end
				io_cnt++;
			end
			if (led)
				done = 1'b1;
		end

		// halted core must stay silent with led held
		repeat (post_halt_cycles)
		begin
			@(negedge clk);
			if (io_strobe)
			begin
				$display("%s: io_strobe after the core halted", test_name[t]);
				test_errors++;
			end
			if (!led)
			begin
				$display("%s: led dropped after the core halted", test_name[t]);
				test_errors++;
			end
		end

		if (io_cnt < exp_io_cnt[t])
		begin
			$display("%s: %0d of %0d io strobes never arrived", test_name[t],
				exp_io_cnt[t] - io_cnt, exp_io_cnt[t]);
			test_errors++;
		end
		if (dbg_reg !== exp_dbg[t])
		begin
			$display("ERROR %s: dbg_reg expected %h actual %h", test_name[t],
				exp_dbg[t], dbg_reg);
			test_errors++;
		end

		if (test_errors == 0)
		begin
			$display("PASS %s", test_name[t]);
			tests_passed++;
		end
		else
		begin
			$display("FAIL %s with %0d errors", test_name[t], test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
	endtask

	initial
	begin
		btnC         = 1'b1;
		load_en      = 1'b0;
		load_addr    = '0;
		load_data    = 8'h00;
		rng_state    = 32'hbcd2_f1e3;
		test_errors  = 0;
		total_errors = 0;
		tests_passed = 0;
		tests_failed = 0;
		build_table();
		for (int t = 0; t < num_tests; t++)
		begin
			run_test(t);
		end
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			num_tests, tests_passed, tests_failed, total_errors);
		if (total_errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial
	begin
		repeat (watchdog_cycles) @(posedge clk);
		$display("watchdog expired after %0d cycles, the core hung or never halted",
			watchdog_cycles);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
